/* sim.f */
+incdir+tb
hdl/char_engine_pkg.sv
hdl/field_table.sv
hdl/screen_sequencer.sv
hdl/glyph_rom.sv
hdl/char_writer.sv
hdl/char_engine.sv
tb/tb_char_engine.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tb_char_engine
FILELIST := sim.f
OBJ_DIR := obj_dir

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb/char_model.svh */
`ifndef CHAR_MODEL_SVH
`define CHAR_MODEL_SVH

// expected writes of one pass, in order
char_engine_pkg::frame_addr_t exp_addr[$];
logic [7:0] exp_byte[$];
int exp_field[$]; // 0 label, 1 register, 2 cycles, 3 debug

int check_count = 0;
int error_count = 0;

// bitmaps for codes 0x00 to 0x28, top row in the high byte
localparam logic [63:0] GLYPHS [0:40] = '{
	64'h3C42_4242_4242_423C, 64'h1838_7818_1818_187E, 64'h3C66_660C_1830_607E,
	64'h7C06_067C_0606_067C, 64'h0E16_2646_467E_0606, 64'h7E60_6078_0C06_0C78,
	64'h3C40_407C_4242_423C, 64'h7E06_0606_0C18_3060, 64'h3C42_423C_4242_423C,
	64'h3C46_4646_3E06_0606, 64'h3C42_4242_7E42_4242, 64'h7C42_427C_4642_467C,
	64'h3E60_6060_6060_603E, 64'h7C62_6262_6262_627C, 64'h3E60_607E_6060_603E,
	64'h7E60_607E_6060_6060, 64'h3C60_606E_6666_663C, 64'h6666_667E_6666_6666,
	64'h7E18_1818_1818_187E, 64'h7E06_0606_0606_663C, 64'h6666_6C70_706C_6666,
	64'h6060_6060_6060_607E, 64'h4266_5A5A_4242_4242, 64'h4242_6252_4A46_4242,
	64'h3C42_4242_4242_423C, 64'h7C42_4242_7C60_6060, 64'h3C42_4242_4242_443A,
	64'h3C42_4242_7C58_4C46, 64'h3C40_403C_0202_023C, 64'h7E18_1818_1818_1818,
	64'h4242_4242_4242_423C, 64'h4242_4242_4242_2418, 64'h4242_4242_5A5A_6642,
	64'h4242_2418_1824_4242, 64'h4242_4224_1818_1818, 64'h7E06_060C_3060_607E,
	64'h0000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_007E_0000_0000,
	64'h0018_1800_0018_1800, 64'h0000_0000_0000_C0C0
};

// ascii to character code
function automatic logic [5:0] code_of(input byte c);
	if (c >= "0" && c <= "9")
		return 6'(c - "0");
	if (c >= "A" && c <= "Z")
		return 6'(c - "A" + 10);
	if (c == ":")
		return 6'h27;
	return 6'h24; // anything else renders as space
endfunction

task automatic put_char(input int row, input int col, input logic [5:0] code, input int field);
	logic [63:0] bits;
	int line;
	bits = (code <= 6'h28) ? GLYPHS[code] : 64'h0;
	for (line = 0; line < char_engine_pkg::LINES_PER_CHAR; line++) begin
		exp_addr.push_back(char_engine_pkg::frame_addr_t'(
			(row * char_engine_pkg::LINES_PER_CHAR + line) * char_engine_pkg::SCREEN_COLS + col));
		exp_byte.push_back((line == 0) ? 8'h00 : bits[63 - 8 * (line - 1) -: 8]);
		exp_field.push_back(field);
	end
endtask

task automatic put_text(input int row, input int col, input string s, input int field);
	for (int i = 0; i < s.len(); i++)
		put_char(row, col + i, code_of(s[i]), field);
endtask

// hex digits, most significant first
task automatic put_hex(input int row, input int col, input logic [31:0] value, input int digits,
		input int field);
	for (int i = 0; i < digits; i++)
		put_char(row, col + i, {2'b00, value[4 * (digits - 1 - i) +: 4]}, field);
endtask

// whole screen from the current register file, cycle counter and flags
task automatic build_screen();
	exp_addr.delete();
	exp_byte.delete();
	exp_field.delete();
	put_text(0, 0, "REGISTERS", 0);
	put_text(NUM_REGS + 2, 0, "CYCLES:", 0);
	put_text(NUM_REGS + 4, 0, "DEBUG", 0);
	for (int r = 0; r < NUM_REGS; r++) begin
		put_hex(r + 1, 0, 32'(r), 2, 1);
		put_char(r + 1, 2, code_of(":"), 1);
		put_hex(r + 1, 3, reg_file[r], 8, 1);
	end
	put_hex(NUM_REGS + 2, 8, {15'd0, cycle_counter}, 5, 2);
	for (int g = 0; g < 4; g++) begin
		put_char(NUM_REGS + 5, 5 * g, code_of(" "), 3);
		for (int b = 0; b < 4; b++)
			put_char(NUM_REGS + 5, 5 * g + 1 + b, debug[4 * g + b] ? code_of("T") : code_of("F"), 3);
	end
endtask

task automatic compare_addr(input string name, input char_engine_pkg::frame_addr_t got,
		input char_engine_pkg::frame_addr_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Fail %t %s: got 0x%h, expected 0x%h", $realtime, name, got, exp);
	end
endtask

task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Fail %t %s: got 0x%h, expected 0x%h", $realtime, name, got, exp);
	end
endtask

task automatic compare_sel(input string name, input logic [4:0] got, input logic [4:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Fail %t %s: got %0d, expected %0d", $realtime, name, got, exp);
	end
endtask

task automatic compare_count(input string name, input int got, input int exp);
	check_count++;
	if (got != exp) begin
		error_count++;
		$display("Fail %t %s: got %0d, expected %0d", $realtime, name, got, exp);
	end
endtask

`endif

/* tb/tb_char_engine.sv */
`timescale 1ns/1ps

module tb_char_engine;

	localparam int NUM_REGS = 32;
	localparam int PASSES = 3;
	localparam int PASS_WRITES = char_engine_pkg::LINES_PER_CHAR * (46 + 11 * NUM_REGS);
	localparam int WATCHDOG_CYCLES = PASSES * PASS_WRITES * 4;

	logic clock = 1'b0;
	logic rst_n;
	logic [31:0] reg_data;
	logic [16:0] cycle_counter;
	logic [15:0] debug;
	logic [4:0] reg_sel;
	logic mem_valid;
	logic mem_ready;
	char_engine_pkg::frame_addr_t mem_addr;
	logic [7:0] mem_byte;
	logic frame_done;

	logic [31:0] reg_file [NUM_REGS];
	logic [4:0] sel_q = '0; // select as seen one cycle earlier
	logic [4:0] sel_seen = '0; // last register select
	integer seed;
	logic new_pass_due; // sources change right after frame_done
	int passes_done = 0;
	int write_idx = 0;
	int reset_cycles = 0;
	int reset_errors = 0;
	int stall_checks = 0;
	int stall_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int pass_err_base = 0;
	int err_before;
	int field_errors [4];
	logic stall_seen = 1'b0;
	char_engine_pkg::frame_addr_t stall_addr;
	logic [7:0] stall_byte;

	`include "char_model.svh"

	char_engine #(
		.NUM_REGS(NUM_REGS)
	) i_char_engine (
		.clock(clock),
		.rst_n(rst_n),
		.reg_data(reg_data),
		.cycle_counter(cycle_counter),
		.debug(debug),
		.reg_sel(reg_sel),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_byte(mem_byte),
		.frame_done(frame_done)
	);

	always #50 clock = ~clock; // 100 ns period

	task automatic randomize_sources();
		for (int r = 0; r < NUM_REGS; r++)
			reg_file[r] = $random(seed);
		cycle_counter = 17'($random(seed));
		debug = 16'($random(seed));
	endtask

	task automatic report_test(input string name, input int errs, input string detail);
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("%s: %s, %0d errors", name, detail, errs);
	endtask

	task automatic finish_pass();
		compare_count("writes in pass", write_idx, exp_addr.size());
		passes_done++;
		report_test($sformatf("pass %0d", passes_done), error_count - pass_err_base,
			$sformatf("%0d writes, label %0d, register %0d, cycles %0d, debug %0d bad",
				write_idx, field_errors[0], field_errors[1], field_errors[2], field_errors[3]));
		for (int f = 0; f < 4; f++)
			field_errors[f] = 0;
		write_idx = 0;
		pass_err_base = error_count;
		new_pass_due = 1'b1;
	endtask

	// inputs move 1 ns after the edge
	always @(posedge clock) begin
		#1;
		mem_ready = ({$random(seed)} % 10) < 7; // about 70% ready
		if (new_pass_due) begin
			randomize_sources();
			build_screen();
			new_pass_due = 1'b0;
		end
		reg_data = reg_file[sel_q]; // register file answers one cycle after the select
		sel_q = reg_sel;
	end

	// outputs are sampled on the falling edge
	always @(negedge clock) begin
		if (!rst_n) begin
			reset_cycles++;
			if (mem_valid !== 1'b0 || frame_done !== 1'b0) begin
				reset_errors++;
				error_count++;
				$display("mem_valid or frame_done went high during reset at %t", $realtime);
			end
		end else begin
			if (reg_sel !== sel_seen) begin
				err_before = error_count;
				compare_sel("reg_sel", reg_sel, sel_seen + 5'd1); // registers read in order
				if (error_count != err_before)
					field_errors[1]++;
				sel_seen = reg_sel;
			end
			if (stall_seen) begin
				stall_checks++;
				err_before = error_count;
				if (mem_valid !== 1'b1) begin
					error_count++;
					$display("mem_valid dropped during a stall at %t", $realtime);
				end else begin
					compare_addr("mem_addr", mem_addr, stall_addr);
					compare_byte("mem_byte", mem_byte, stall_byte);
				end
				if (error_count != err_before)
					stall_errors++;
			end
			if (mem_valid === 1'b1 && mem_ready === 1'b1) begin
				if (write_idx >= exp_addr.size()) begin
					error_count++;
					$display("write to 0x%h at %t goes past the %0d writes of the pass",
						mem_addr, $realtime, exp_addr.size());
				end else begin
					err_before = error_count;
					compare_addr("mem_addr", mem_addr, exp_addr[write_idx]);
					compare_byte("mem_byte", mem_byte, exp_byte[write_idx]);
					if (error_count != err_before)
						field_errors[exp_field[write_idx]]++;
				end
				write_idx++;
			end
			stall_seen = (mem_valid === 1'b1 && mem_ready === 1'b0);
			stall_addr = mem_addr;
			stall_byte = mem_byte;
			if (frame_done === 1'b1)
				finish_pass();
		end
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		seed = 32;
		rst_n = 1'b0;
		mem_ready = 1'b0;
		reg_data = '0;
		new_pass_due = 1'b0;
		for (int f = 0; f < 4; f++)
			field_errors[f] = 0;
		randomize_sources();
		build_screen();
		repeat (10) @(posedge clock);
		#1 rst_n = 1'b1;
		report_test("reset", reset_errors, $sformatf("%0d cycles held low", reset_cycles));
		pass_err_base = error_count;
		wait (passes_done == PASSES);
		report_test("stall hold", stall_errors, $sformatf("%0d stalled cycles", stall_checks));
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// three passes at four cycles per write at most
	initial begin
		repeat (WATCHDOG_CYCLES + 10) @(posedge clock);
		$display("watchdog expired after %0d cycles with %0d of %0d passes done",
			WATCHDOG_CYCLES, passes_done, PASSES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* hdl/char_engine.sv */
`timescale 1ns/1ps

module char_engine #(
	parameter int NUM_REGS = 32
) (
	input  logic clock,
	input  logic rst_n,
	input  logic [31:0] reg_data,
	input  logic [16:0] cycle_counter,
	input  logic [15:0] debug,
	output logic [4:0] reg_sel,
	output logic mem_valid,
	input  logic mem_ready,
	output char_engine_pkg::frame_addr_t mem_addr,
	output logic [7:0] mem_byte,
	output logic frame_done
);

	logic [5:0] slot;
	char_engine_pkg::field_kind_t kind;
	logic [5:0] row;
	logic [6:0] col;
	logic [4:0] length;
	char_engine_pkg::char_code_t label_char;
	logic [4:0] char_index;
	logic char_valid;
	logic char_ready;
	char_engine_pkg::char_code_t char_code;
	logic [5:0] char_row;
	logic [6:0] char_col;
	char_engine_pkg::char_code_t glyph_code;
	char_engine_pkg::glyph_t glyph;
	logic last_write; // writer finished a character

	field_table #(
		.NUM_REGS(NUM_REGS)
	) i_field_table (
		.slot(slot),
		.kind(kind),
		.row(row),
		.col(col),
		.length(length),
		.label_char(label_char),
		.char_index(char_index)
	);

	screen_sequencer #(
		.NUM_REGS(NUM_REGS)
	) i_screen_sequencer (
		.clock(clock),
		.rst_n(rst_n),
		.reg_data(reg_data),
		.cycle_counter(cycle_counter),
		.debug(debug),
		.reg_sel(reg_sel),
		.slot(slot),
		.kind(kind),
		.row(row),
		.col(col),
		.length(length),
		.label_char(label_char),
		.char_index(char_index),
		.char_valid(char_valid),
		.char_ready(char_ready),
		.char_code(char_code),
		.char_row(char_row),
		.char_col(char_col),
		.last_write(last_write),
		.frame_done(frame_done)
	);

	glyph_rom i_glyph_rom (
		.code(glyph_code),
		.glyph(glyph)
	);

	char_writer i_char_writer (
		.clock(clock),
		.rst_n(rst_n),
		.char_valid(char_valid),
		.char_ready(char_ready),
		.char_code(char_code),
		.char_row(char_row),
		.char_col(char_col),
		.glyph(glyph),
		.glyph_code(glyph_code),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_byte(mem_byte),
		.last_write(last_write)
	);

endmodule

/* hdl/char_writer.sv */
`timescale 1ns/1ps

module char_writer (
	input  logic clock,
	input  logic rst_n,
	input  logic char_valid,
	output logic char_ready,
	input  char_engine_pkg::char_code_t char_code,
	input  logic [5:0] char_row,
	input  logic [6:0] char_col,
	input  char_engine_pkg::glyph_t glyph,
	output char_engine_pkg::char_code_t glyph_code,
	output logic mem_valid,
	input  logic mem_ready,
	output char_engine_pkg::frame_addr_t mem_addr,
	output logic [7:0] mem_byte,
	output logic last_write
);

	logic [3:0] line; // 0 is the blank line, 1..8 glyph rows
	char_engine_pkg::char_code_t code_q;
	logic [5:0] row_q;
	logic [6:0] col_q;
	logic write_done;
	logic accept;

	assign write_done = mem_valid && mem_ready;
	assign last_write = write_done && (line == 4'd8);
	assign char_ready = !mem_valid || last_write; // take the next one back to back
	assign accept = char_valid && char_ready;
	assign glyph_code = code_q;

	assign mem_addr = char_engine_pkg::frame_addr_t'(
		(row_q * char_engine_pkg::LINES_PER_CHAR + line) * char_engine_pkg::SCREEN_COLS + col_q);
	assign mem_byte = (line == 4'd0) ? 8'h00 : glyph.rows[3'(line - 4'd1)];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mem_valid <= 1'b0;
			line <= '0;
		end else if (accept) begin
			mem_valid <= 1'b1; // first write the cycle after
			line <= '0;
		end else if (write_done) begin
			if (line == 4'd8)
				mem_valid <= 1'b0;
			else
				line <= line + 4'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			code_q <= char_code;
			row_q <= char_row;
			col_q <= char_col;
		end
	end

	// write port must hold through a stall
	assert property (@(posedge clock) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_byte));

	assert property (@(posedge clock) !rst_n |=> !mem_valid);

endmodule

/* hdl/glyph_rom.sv */
`timescale 1ns/1ps

module glyph_rom (
	input  char_engine_pkg::char_code_t code,
	output char_engine_pkg::glyph_t glyph
);

	// each word reads top row first, two hex digits per pixel row
	always_comb begin
		case (code)
			6'h00: glyph.word = 64'h3C42_4242_4242_423C; // 0
			6'h01: glyph.word = 64'h1838_7818_1818_187E;
			6'h02: glyph.word = 64'h3C66_660C_1830_607E;
			6'h03: glyph.word = 64'h7C06_067C_0606_067C;
			6'h04: glyph.word = 64'h0E16_2646_467E_0606;
			6'h05: glyph.word = 64'h7E60_6078_0C06_0C78;
			6'h06: glyph.word = 64'h3C40_407C_4242_423C;
			6'h07: glyph.word = 64'h7E06_0606_0C18_3060;
			6'h08: glyph.word = 64'h3C42_423C_4242_423C;
			6'h09: glyph.word = 64'h3C46_4646_3E06_0606; // 9
			6'h0A: glyph.word = 64'h3C42_4242_7E42_4242; // A
			6'h0B: glyph.word = 64'h7C42_427C_4642_467C;
			6'h0C: glyph.word = 64'h3E60_6060_6060_603E;
			6'h0D: glyph.word = 64'h7C62_6262_6262_627C;
			6'h0E: glyph.word = 64'h3E60_607E_6060_603E;
			6'h0F: glyph.word = 64'h7E60_607E_6060_6060; // F
			6'h10: glyph.word = 64'h3C60_606E_6666_663C;
			6'h11: glyph.word = 64'h6666_667E_6666_6666;
			6'h12: glyph.word = 64'h7E18_1818_1818_187E;
			6'h13: glyph.word = 64'h7E06_0606_0606_663C;
			6'h14: glyph.word = 64'h6666_6C70_706C_6666;
			6'h15: glyph.word = 64'h6060_6060_6060_607E; // L
			6'h16: glyph.word = 64'h4266_5A5A_4242_4242;
			6'h17: glyph.word = 64'h4242_6252_4A46_4242;
			6'h18: glyph.word = 64'h3C42_4242_4242_423C;
			6'h19: glyph.word = 64'h7C42_4242_7C60_6060;
			6'h1A: glyph.word = 64'h3C42_4242_4242_443A;
			6'h1B: glyph.word = 64'h3C42_4242_7C58_4C46; // R
			6'h1C: glyph.word = 64'h3C40_403C_0202_023C;
			6'h1D: glyph.word = 64'h7E18_1818_1818_1818; // T
			6'h1E: glyph.word = 64'h4242_4242_4242_423C;
			6'h1F: glyph.word = 64'h4242_4242_4242_2418;
			6'h20: glyph.word = 64'h4242_4242_5A5A_6642;
			6'h21: glyph.word = 64'h4242_2418_1824_4242;
			6'h22: glyph.word = 64'h4242_4224_1818_1818;
			6'h23: glyph.word = 64'h7E06_060C_3060_607E; // Z
			6'h24: glyph.word = 64'h0000_0000_0000_0000; // space
			6'h25: glyph.word = 64'hFFFF_FFFF_FFFF_FFFF; // filled block
			6'h26: glyph.word = 64'h0000_007E_0000_0000; // minus
			6'h27: glyph.word = 64'h0018_1800_0018_1800; // colon
			6'h28: glyph.word = 64'h0000_0000_0000_C0C0; // dot, bottom left
			default: glyph.word = 64'h0;
		endcase
	end

endmodule

/* hdl/screen_sequencer.sv */
`timescale 1ns/1ps

module screen_sequencer #(
	parameter int NUM_REGS = 32
) (
	input  logic clock,
	input  logic rst_n,
	input  logic [31:0] reg_data,
	input  logic [16:0] cycle_counter,
	input  logic [15:0] debug,
	output logic [4:0] reg_sel,
	output logic [5:0] slot,
	input  char_engine_pkg::field_kind_t kind,
	input  logic [5:0] row,
	input  logic [6:0] col,
	input  logic [4:0] length,
	input  char_engine_pkg::char_code_t label_char,
	output logic [4:0] char_index,
	output logic char_valid,
	input  logic char_ready,
	output char_engine_pkg::char_code_t char_code,
	output logic [5:0] char_row,
	output logic [6:0] char_col,
	input  logic last_write,
	output logic frame_done
);

	localparam logic [5:0] LAST_SLOT = 6'(NUM_REGS + 4);

	localparam logic [2:0] S_START = 3'd0; // snapshot sources
	localparam logic [2:0] S_LOAD = 3'd1; // field lookup
	localparam logic [2:0] S_WAIT = 3'd2; // register read settles
	localparam logic [2:0] S_EMIT = 3'd3;
	localparam logic [2:0] S_DRAIN = 3'd4; // last character still being written
	localparam logic [2:0] S_DONE = 3'd5;

	logic [2:0] state;
	logic [4:0] reg_idx;
	logic [31:0] reg_word;
	logic [16:0] cycles_snap;
	logic [15:0] debug_snap;
	logic [31:0] hex_value;
	logic [4:0] nib;
	logic [4:0] dbg_group;
	logic [4:0] dbg_pos;
	logic [3:0] dbg_bit;
	logic char_last;

	assign reg_sel = reg_idx;
	assign char_valid = (state == S_EMIT);
	assign frame_done = (state == S_DONE);
	assign char_row = row;
	assign char_col = col + 7'(char_index);
	assign char_last = (char_index == length - 5'd1);

	// hex digits go most significant first
	assign hex_value = (kind == char_engine_pkg::FIELD_REG) ? reg_word : {15'd0, cycles_snap};
	assign nib = length - 5'd1 - char_index;

	// debug field is five characters per group, a space then four flags
	assign dbg_group = char_index / 5'd5;
	assign dbg_pos = char_index - dbg_group * 5'd5;
	assign dbg_bit = 4'({dbg_group[1:0], 2'b00} + dbg_pos - 5'd1);

	always_comb begin
		case (kind)
			char_engine_pkg::FIELD_REG: begin
				if (char_index == 5'd0)
					char_code = {5'd0, reg_idx[4]};
				else if (char_index == 5'd1)
					char_code = {2'b00, reg_idx[3:0]};
				else if (char_index == 5'd2)
					char_code = char_engine_pkg::CHAR_COLON;
				else
					char_code = {2'b00, hex_value[{nib[2:0], 2'b00} +: 4]};
			end
			char_engine_pkg::FIELD_CYCLES: char_code = {2'b00, hex_value[{nib[2:0], 2'b00} +: 4]};
			char_engine_pkg::FIELD_DEBUG: begin
				if (dbg_pos == 5'd0)
					char_code = char_engine_pkg::CHAR_SPACE;
				else if (debug_snap[dbg_bit])
					char_code = char_engine_pkg::CHAR_T;
				else
					char_code = char_engine_pkg::CHAR_F;
			end
			default: char_code = label_char;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_START;
			slot <= '0;
			char_index <= '0;
			reg_idx <= '0;
		end else begin
			case (state)
				S_START: begin
					slot <= '0;
					char_index <= '0;
					reg_idx <= '0;
					state <= S_LOAD;
				end
				S_LOAD: state <= (kind == char_engine_pkg::FIELD_REG) ? S_WAIT : S_EMIT;
				S_WAIT: state <= S_EMIT;
				S_EMIT: begin
					if (char_ready) begin
						if (char_last) begin
							char_index <= '0;
							if (kind == char_engine_pkg::FIELD_REG)
								reg_idx <= reg_idx + 5'd1; // next register, reg_sel moves now
							if (slot == LAST_SLOT) begin
								state <= S_DRAIN;
							end else begin
								slot <= slot + 6'd1;
								state <= S_LOAD;
							end
						end else begin
							char_index <= char_index + 5'd1;
						end
					end
				end
				S_DRAIN: if (last_write) state <= S_DONE;
				S_DONE: state <= S_START;
				default: state <= S_START;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_START) begin
			cycles_snap <= cycle_counter;
			debug_snap <= debug;
		end
		if (state == S_WAIT)
			reg_word <= reg_data; // second edge with reg_sel steady
	end

	// a stalled character must not change under the writer
	assert property (@(posedge clock) disable iff (!rst_n)
		char_valid && !char_ready |=> char_valid && $stable(char_code));

endmodule

/* hdl/field_table.sv */
`timescale 1ns/1ps

module field_table #(
	parameter int NUM_REGS = 32
) (
	input  logic [5:0] slot,
	output char_engine_pkg::field_kind_t kind,
	output logic [5:0] row,
	output logic [6:0] col,
	output logic [4:0] length,
	output char_engine_pkg::char_code_t label_char,
	input  logic [4:0] char_index
);

	localparam logic [5:0] CYCLES_SLOT = 6'(NUM_REGS + 3);
	localparam logic [5:0] CYCLES_ROW = 6'(NUM_REGS + 2);
	localparam logic [5:0] DEBUG_ROW = 6'(NUM_REGS + 5);

	// label text, first character at index 0
	localparam char_engine_pkg::char_code_t [0:8] TXT_REGISTERS = {
		6'h1B, 6'h0E, 6'h10, 6'h12, 6'h1C, 6'h1D, 6'h0E, 6'h1B, 6'h1C
	};
	localparam char_engine_pkg::char_code_t [0:6] TXT_CYCLES = {
		6'h0C, 6'h22, 6'h0C, 6'h15, 6'h0E, 6'h1C, 6'h27
	};
	localparam char_engine_pkg::char_code_t [0:4] TXT_DEBUG = {
		6'h0D, 6'h0E, 6'h0B, 6'h1E, 6'h10
	};

	// slot layout: three labels, the registers, cycles value, debug flags
	always_comb begin
		kind = char_engine_pkg::FIELD_LABEL;
		row = '0;
		col = '0;
		length = '0;
		if (slot == 6'd0) begin
			length = 5'd9; // REGISTERS
		end else if (slot == 6'd1) begin
			row = CYCLES_ROW;
			length = 5'd7; // CYCLES:
		end else if (slot == 6'd2) begin
			row = 6'(NUM_REGS + 4);
			length = 5'd5; // DEBUG
		end else if (slot < CYCLES_SLOT) begin
			kind = char_engine_pkg::FIELD_REG;
			row = slot - 6'd2; // register r on row r+1
			length = 5'd11;
		end else if (slot == CYCLES_SLOT) begin
			kind = char_engine_pkg::FIELD_CYCLES;
			row = CYCLES_ROW;
			col = 7'd8; // right after the label
			length = 5'd5;
		end else begin
			kind = char_engine_pkg::FIELD_DEBUG;
			row = DEBUG_ROW;
			length = 5'(char_engine_pkg::MAX_FIELD_LEN);
		end
	end

	always_comb begin
		label_char = char_engine_pkg::CHAR_SPACE;
		case (slot)
			6'd0: if (char_index < 5'd9) label_char = TXT_REGISTERS[char_index];
			6'd1: if (char_index < 5'd7) label_char = TXT_CYCLES[char_index];
			6'd2: if (char_index < 5'd5) label_char = TXT_DEBUG[char_index];
			default: label_char = char_engine_pkg::CHAR_SPACE; // not a label slot
		endcase
	end

endmodule

/* hdl/char_engine_pkg.sv */
package char_engine_pkg;

	localparam int SCREEN_COLS = 80; // characters per screen line
	localparam int LINES_PER_CHAR = 9; // one blank line plus eight glyph lines
	localparam int MAX_FIELD_LEN = 20; // debug flags field

	// character codes
	// 0x00-0x0F hex digits, 0x0A-0x23 letters, then the symbols
	typedef logic [5:0] char_code_t;

	localparam char_code_t CHAR_F = 6'h0F;
	localparam char_code_t CHAR_T = 6'h1D;
	localparam char_code_t CHAR_SPACE = 6'h24;
	localparam char_code_t CHAR_BLOCK = 6'h25;
	localparam char_code_t CHAR_MINUS = 6'h26;
	localparam char_code_t CHAR_COLON = 6'h27;
	localparam char_code_t CHAR_DOT = 6'h28;

	typedef logic [15:0] frame_addr_t; // byte address into frame memory

	// one glyph, either as a whole word or as pixel rows
	// rows[0] is the top row and sits in word[63:56], bit 7 is the leftmost pixel
	typedef union packed {
		logic [63:0] word;
		logic [0:7][7:0] rows;
	} glyph_t;

	typedef logic [1:0] field_kind_t;

	localparam field_kind_t FIELD_LABEL = 2'd0; // fixed text
	localparam field_kind_t FIELD_REG = 2'd1; // index, colon, eight hex digits
	localparam field_kind_t FIELD_CYCLES = 2'd2; // five hex digits
	localparam field_kind_t FIELD_DEBUG = 2'd3; // T/F flags in groups of four

endpackage
